//--- Makefile
# Verilator build for the RV32I core testbench
# override on the command line, e.g. make sim SEED=7 TRACE=--trace

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= flist.f
SEED      ?= 0
TRACE     ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(TRACE) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/branch_target_buffer.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core.sv
verif/rv_core_tb.sv

//--- include/rv_core_tb_prog.svh
////////////////////////////////////////////////////////////////////////////
// test program for the core testbench
// instruction encoders, the program image and its expected retire table
////////////////////////////////////////////////////////////////////////////
`ifndef RV_CORE_TB_PROG_SVH
`define RV_CORE_TB_PROG_SVH

function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_op};
endfunction

function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], rv_pkg::opc_branch};
endfunction

function automatic logic [31:0] enc_j(int imm, int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opc_jal};
endfunction

// arithmetic chain, a three-pass loop, then jal and jalr
function automatic logic [31:0] prog_word(int idx);
  case (idx)
    0:  return enc_i(5, 0, 0, 1, rv_pkg::opc_op_imm);  // x1 = 5
    1:  return enc_i(3, 1, 0, 2, rv_pkg::opc_op_imm);  // x2 = x1 + 3
    2:  return enc_r(0, 2, 1, 0, 3);                   // x3 = x1 + x2
    3:  return enc_r(32, 1, 3, 0, 4);                  // x4 = x3 - x1
    4:  return enc_i(2, 4, 1, 5, rv_pkg::opc_op_imm);  // x5 = x4 << 2
    5:  return enc_i(1, 0, 0, 0, rv_pkg::opc_op_imm);  // rd zero
    6:  return enc_i(3, 0, 0, 6, rv_pkg::opc_op_imm);  // loop count
    7:  return enc_i(1, 7, 0, 7, rv_pkg::opc_op_imm);
    8:  return enc_i(-1, 6, 0, 6, rv_pkg::opc_op_imm);
    9:  return enc_b(-8, 0, 6, 1);                     // bne x6, x0
    10: return enc_j(12, 8);                           // jal x8 to 52
    13: return enc_i(65, 0, 0, 10, rv_pkg::opc_op_imm);
    14: return enc_i(0, 10, 0, 11, rv_pkg::opc_jalr);  // to 64
    16: return enc_i(9, 0, 0, 13, rv_pkg::opc_op_imm);
    17: return enc_j(0, 0);                            // spin
    default: return enc_i(2, 0, 0, 9, rv_pkg::opc_op_imm);  // wrong path
  endcase
endfunction

localparam int prog_len  = 18;
localparam int exp_count = 16;
localparam int loop_redirects = 2;

localparam logic [31:0] exp_pc [exp_count] = '{0, 4, 8, 12, 16, 24, 28, 32,
                                               28, 32, 28, 32, 40, 52, 56, 64};
localparam logic [4:0] exp_rd [exp_count] = '{1, 2, 3, 4, 5, 6, 7, 6,
                                              7, 6, 7, 6, 8, 10, 11, 13};
localparam logic [31:0] exp_data [exp_count] = '{5, 8, 13, 8, 32, 3, 1, 2,
                                                 2, 1, 3, 0, 44, 65, 60, 9};

`endif

//--- verif/rv_core_tb.sv
////////////////////////////////////////////////////////////////////////////
// rv_core_tb
// testbench for the pipelined RV32I core: instruction memory model,
// reset and clock, and retire-port checks against the expected table
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_core_tb;

  `include "rv_core_tb_prog.svh"

  localparam int imem_bits      = 6;   // 64 words
  localparam int imem_words     = 2 ** imem_bits;
  localparam int loop_exit_idx  = 11;  // retire of x6 reaching zero
  localparam int total_redirects = loop_redirects + 3;  // jal, jalr, spin jal
  localparam int first_retire   = 4;   // fetch in cycle 0, retire 4 later
  localparam int drain_cycles   = 20;
  // program runs well under 100 cycles, generous margin on top
  localparam int timeout_cycles = 2000;

  logic              clk;
  logic              reset;
  rv_pkg::word_t     imem_addr;
  rv_pkg::word_t     imem_data;
  logic              retire_valid;
  rv_pkg::reg_addr_t retire_rd;
  rv_pkg::word_t     retire_data;
  rv_pkg::word_t     retire_pc;
  logic              redirect;

  rv_pkg::word_t imem [imem_words];
  int retire_count = 0;
  int redirect_count = 0;
  int cycle_count = 0;

  rv_core dut_i (.*);

  assign imem_data = imem[imem_addr[imem_bits+1:2]];  // same-cycle read

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
    $display("FAILED %s expected %0d actual %0d", test, expected, actual);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_failure(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    if (!reset) cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      report_failure("timeout: program did not finish retiring");
    end
  end

  // retire and redirect checks, sampled away from the rising edge
  always @(negedge clk) begin
    if (!reset) begin
      if (redirect) redirect_count++;
      if (retire_valid) begin
        if (retire_count >= exp_count) begin
          report_failure("retire seen after the last expected instruction");
        end else begin
          if (retire_count == 0)
            first_retire_a: assert (cycle_count == first_retire)
              else report_mismatch("first_retire_cycle", first_retire, cycle_count);
          retire_pc_a: assert (retire_pc == exp_pc[retire_count])
            else report_mismatch("retire_pc", exp_pc[retire_count], retire_pc);
          retire_rd_a: assert (retire_rd == exp_rd[retire_count])
            else report_mismatch("retire_rd", exp_rd[retire_count], retire_rd);
          retire_data_a: assert (retire_data == exp_data[retire_count])
            else report_mismatch("retire_data", exp_data[retire_count], retire_data);
          if (retire_count == loop_exit_idx)
            loop_redirect_a: assert (redirect_count == loop_redirects)
              else report_mismatch("loop_redirects", loop_redirects, redirect_count);
          retire_count++;
        end
      end
    end
  end

  no_early_redirect_a: assert property (@(posedge clk) disable iff (reset)
    retire_count == 0 |-> !redirect && !retire_valid)
    else report_failure("redirect or retire_valid high before the first retire");

  rd_zero_a: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire_rd != '0)
    else report_failure("retire_valid asserted for an instruction with rd zero");

  redirect_pulse_a: assert property (@(posedge clk) disable iff (reset)
    redirect |=> !redirect)
    else report_failure("redirect held high for more than one cycle");

  imem_range_a: assert property (@(posedge clk) disable iff (reset)
    imem_addr[31:imem_bits+2] == '0)
    else report_failure("fetch address outside the instruction memory");

  initial begin
    logic [31:0] fill;
    reset = 1'b1;
    void'($urandom(32'h73a0));
    for (int i = 0; i < imem_words; i++) begin
      if (i < prog_len) begin
        imem[i] = prog_word(i);
      end else begin
        fill = $urandom ^ (i << 20);  // word index lands in the immediate
        imem[i] = {fill[31:7], rv_pkg::opc_op_imm};  // harmless filler
      end
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    reset_pc_a: assert (imem_addr == rv_pkg::reset_pc)
      else report_mismatch("reset_pc", rv_pkg::reset_pc, imem_addr);
    wait (retire_count == exp_count);
    repeat (drain_cycles) @(negedge clk);  // spin loop, nothing more may retire
    total_redirect_a: assert (redirect_count == total_redirects)
      else report_mismatch("total_redirects", total_redirects, redirect_count);
    $display("No errors");
    $finish;
  end

endmodule

//--- verilog/branch_target_buffer.sv
////////////////////////////////////////////////////////////////////////////
// branch_target_buffer
// direct-mapped tagged target table, looked up by the fetch pc and
// written by execute on a resolved taken mispredict
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_target_buffer #(
  parameter int btb_index_bits = 5
) (
  input  logic          clk,
  input  logic          reset,
  input  rv_pkg::word_t lookup_pc,
  output logic          btb_hit,
  output rv_pkg::word_t btb_target,
  input  logic          btb_write,
  input  rv_pkg::word_t btb_write_pc,
  input  rv_pkg::word_t btb_write_target
);

  localparam int entries  = 2 ** btb_index_bits;
  localparam int tag_bits = rv_pkg::xlen - btb_index_bits - 2;

  logic [entries-1:0]  valid;
  logic [tag_bits-1:0] tag [entries];
  rv_pkg::word_t       target [entries];

  logic [btb_index_bits-1:0] rd_idx;
  logic [btb_index_bits-1:0] wr_idx;

  assign rd_idx = lookup_pc[btb_index_bits+1:2];
  assign wr_idx = btb_write_pc[btb_index_bits+1:2];

  assign btb_hit    = valid[rd_idx] && (tag[rd_idx] == lookup_pc[rv_pkg::xlen-1:btb_index_bits+2]);
  assign btb_target = target[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (btb_write) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (btb_write) begin
      tag[wr_idx]    <= btb_write_pc[rv_pkg::xlen-1:btb_index_bits+2];
      target[wr_idx] <= btb_write_target;
    end
  end

  target_aligned_a: assert property (@(posedge clk) disable iff (reset)
    btb_write |-> btb_write_target[1:0] == 2'b00);

endmodule

//--- verilog/decode_stage.sv
////////////////////////////////////////////////////////////////////////////
// decode_stage
// control decode, immediate generation and source selection, followed
// by the ID/EX pipeline register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 id_valid,
  input  rv_pkg::word_t        id_inst,
  input  rv_pkg::word_t        id_pc,
  input  rv_pkg::word_t        id_pred_pc,
  output rv_pkg::reg_addr_t    rs1_addr,
  output rv_pkg::reg_addr_t    rs2_addr,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  output logic                 ex_valid,
  output rv_pkg::word_t        ex_pc,
  output rv_pkg::word_t        ex_pred_pc,
  output rv_pkg::reg_addr_t    ex_rs1,
  output rv_pkg::reg_addr_t    ex_rs2,
  output rv_pkg::reg_addr_t    ex_rd,
  output rv_pkg::word_t        ex_rs1_data,
  output rv_pkg::word_t        ex_rs2_data,
  output rv_pkg::word_t        ex_imm,
  output rv_pkg::alu_op_t      ex_alu_op,
  output logic                 ex_use_imm,
  output logic                 ex_is_branch,
  output rv_pkg::branch_cond_t ex_branch_cond,
  output logic                 ex_is_jal,
  output logic                 ex_is_jalr,
  output logic                 ex_reg_write,
  output logic                 ex_pc_to_reg
);

  logic [2:0] funct3;
  logic known, use_rs1, use_rs2, use_imm, is_branch, is_jal, is_jalr, reg_write;
  logic dec_valid;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::word_t   imm;

  assign funct3 = id_inst[14:12];

  always_comb begin
    known = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    reg_write = 1'b0;
    alu_op = rv_pkg::alu_add;
    imm = {{20{id_inst[31]}}, id_inst[31:20]};  // I form
    case (rv_pkg::opcode_t'(id_inst[6:0]))
      rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
        use_rs1 = 1'b1;
        use_rs2 = (id_inst[6:0] == rv_pkg::opc_op);
        use_imm = !use_rs2;
        reg_write = 1'b1;
        case (funct3)
          3'd0: alu_op = (use_rs2 && id_inst[30]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'd1: alu_op = rv_pkg::alu_sll;
          3'd2: alu_op = rv_pkg::alu_slt;
          3'd3: alu_op = rv_pkg::alu_sltu;
          3'd4: alu_op = rv_pkg::alu_xor;
          3'd5: alu_op = id_inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'd6: alu_op = rv_pkg::alu_or;
          default: alu_op = rv_pkg::alu_and;
        endcase
      end
      rv_pkg::opc_lui: begin
        use_imm = 1'b1;
        reg_write = 1'b1;
        alu_op = rv_pkg::alu_pass_b;
        imm = {id_inst[31:12], 12'b0};
      end
      rv_pkg::opc_branch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        is_branch = 1'b1;
        imm = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
      end
      rv_pkg::opc_jal: begin
        is_jal = 1'b1;
        reg_write = 1'b1;
        imm = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};
      end
      rv_pkg::opc_jalr: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        is_jalr = 1'b1;
        reg_write = 1'b1;
      end
      default: known = 1'b0;  // bubble
    endcase
  end

  // unused sources read as x0 so forwarding never matches them
  assign rs1_addr  = use_rs1 ? id_inst[19:15] : '0;
  assign rs2_addr  = use_rs2 ? id_inst[24:20] : '0;
  assign dec_valid = id_valid && known && !flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_is_jal <= 1'b0;
      ex_is_jalr <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_pc_to_reg <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
      ex_is_branch <= dec_valid && is_branch;
      ex_is_jal <= dec_valid && is_jal;
      ex_is_jalr <= dec_valid && is_jalr;
      ex_reg_write <= dec_valid && reg_write;
      ex_pc_to_reg <= dec_valid && (is_jal || is_jalr);  // link pc+4
    end
  end

  always_ff @(posedge clk) begin
    ex_pc <= id_pc;
    ex_pred_pc <= id_pred_pc;
    ex_rs1 <= rs1_addr;
    ex_rs2 <= rs2_addr;
    ex_rd <= id_inst[11:7];
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm <= imm;
    ex_alu_op <= alu_op;
    ex_use_imm <= use_imm;
    ex_branch_cond <= rv_pkg::branch_cond_t'(funct3);
  end

endmodule

//--- verilog/execute_stage.sv
////////////////////////////////////////////////////////////////////////////
// execute_stage
// operand forwarding, ALU, branch and jump resolution with redirect and
// BTB update, followed by the EX/MEM pipeline register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ex_valid,
  input  rv_pkg::word_t        ex_pc,
  input  rv_pkg::word_t        ex_pred_pc,
  input  rv_pkg::reg_addr_t    ex_rs1,
  input  rv_pkg::reg_addr_t    ex_rs2,
  input  rv_pkg::reg_addr_t    ex_rd,
  input  rv_pkg::word_t        ex_rs1_data,
  input  rv_pkg::word_t        ex_rs2_data,
  input  rv_pkg::word_t        ex_imm,
  input  rv_pkg::alu_op_t      ex_alu_op,
  input  logic                 ex_use_imm,
  input  logic                 ex_is_branch,
  input  rv_pkg::branch_cond_t ex_branch_cond,
  input  logic                 ex_is_jal,
  input  logic                 ex_is_jalr,
  input  logic                 ex_reg_write,
  input  logic                 ex_pc_to_reg,
  input  logic                 wb_we,
  input  rv_pkg::reg_addr_t    wb_rd,
  input  rv_pkg::word_t        wb_data,
  output logic                 redirect,
  output rv_pkg::word_t        redirect_pc,
  output logic                 btb_write,
  output rv_pkg::word_t        btb_write_pc,
  output rv_pkg::word_t        btb_write_target,
  output logic                 mem_valid,
  output rv_pkg::reg_addr_t    mem_rd,
  output rv_pkg::word_t        mem_result,
  output rv_pkg::word_t        mem_pc,
  output logic                 mem_reg_write,
  output logic                 mem_pc_to_reg
);

  rv_pkg::word_t mem_fwd, src_a, src_b, op_b, alu_out, next_pc;
  logic mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b, taken;

  // value the EX/MEM instruction will write, link included
  assign mem_fwd   = mem_pc_to_reg ? mem_pc + 32'd4 : mem_result;
  assign mem_hit_a = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1;
  assign mem_hit_b = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2;
  assign wb_hit_a  = wb_we && wb_rd != '0 && wb_rd == ex_rs1;
  assign wb_hit_b  = wb_we && wb_rd != '0 && wb_rd == ex_rs2;

  assign src_a = mem_hit_a ? mem_fwd : wb_hit_a ? wb_data : ex_rs1_data;  // newest first
  assign src_b = mem_hit_b ? mem_fwd : wb_hit_b ? wb_data : ex_rs2_data;
  assign op_b  = ex_use_imm ? ex_imm : src_b;

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_sub:    alu_out = src_a - op_b;
      rv_pkg::alu_and:    alu_out = src_a & op_b;
      rv_pkg::alu_or:     alu_out = src_a | op_b;
      rv_pkg::alu_xor:    alu_out = src_a ^ op_b;
      rv_pkg::alu_sll:    alu_out = src_a << op_b[4:0];
      rv_pkg::alu_srl:    alu_out = src_a >> op_b[4:0];
      rv_pkg::alu_sra:    alu_out = $signed(src_a) >>> op_b[4:0];
      rv_pkg::alu_slt:    alu_out = {31'b0, $signed(src_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_out = {31'b0, src_a < op_b};
      rv_pkg::alu_pass_b: alu_out = op_b;
      default:            alu_out = src_a + op_b;
    endcase
  end

  always_comb begin
    case (ex_branch_cond)
      rv_pkg::br_eq:  taken = src_a == src_b;
      rv_pkg::br_ne:  taken = src_a != src_b;
      rv_pkg::br_lt:  taken = $signed(src_a) < $signed(src_b);
      rv_pkg::br_ge:  taken = $signed(src_a) >= $signed(src_b);
      rv_pkg::br_ltu: taken = src_a < src_b;
      default:        taken = src_a >= src_b;
    endcase
    taken = taken && ex_is_branch;
  end

  assign next_pc = ex_is_jalr ? {alu_out[31:1], 1'b0} :
                   (taken || ex_is_jal) ? ex_pc + ex_imm : ex_pc + 32'd4;

  assign redirect         = ex_valid && next_pc != ex_pred_pc;
  assign redirect_pc      = next_pc;
  assign btb_write        = redirect && (taken || ex_is_jal || ex_is_jalr);  // not-taken never
  assign btb_write_pc     = ex_pc;
  assign btb_write_target = next_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_pc_to_reg <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      mem_reg_write <= ex_reg_write;
      mem_pc_to_reg <= ex_pc_to_reg;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd <= ex_rd;
    mem_result <= alu_out;
    mem_pc <= ex_pc;
  end

  redirect_ctl_a: assert property (@(posedge clk) disable iff (reset)
    redirect |-> ex_valid && (ex_is_branch || ex_is_jal || ex_is_jalr));

endmodule

//--- verilog/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// fetch_stage
// pc register with next-pc choice between redirect, btb prediction and
// pc+4, followed by the IF/ID pipeline register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_stage (
  input  logic          clk,
  input  logic          reset,
  input  logic          redirect,
  input  rv_pkg::word_t redirect_pc,
  input  logic          btb_hit,
  input  rv_pkg::word_t btb_target,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          id_valid,
  output rv_pkg::word_t id_inst,
  output rv_pkg::word_t id_pc,
  output rv_pkg::word_t id_pred_pc
);

  rv_pkg::word_t pc;
  rv_pkg::word_t pred_pc;

  assign imem_addr = pc;
  assign pred_pc   = btb_hit ? btb_target : pc + 32'd4;  // taken on any hit

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_pkg::reset_pc;
    end else begin
      pc <= redirect ? redirect_pc : pred_pc;  // execute wins over prediction
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= !redirect;  // word fetched now is wrong path
    end
  end

  // payload, qualified by id_valid
  always_ff @(posedge clk) begin
    id_inst    <= imem_data;
    id_pc      <= pc;
    id_pred_pc <= pred_pc;
  end

  pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

//--- verilog/register_file.sv
////////////////////////////////////////////////////////////////////////////
// register_file
// 32 x 32 integer registers, two combinational reads with write-through
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wb_we,
  input  rv_pkg::reg_addr_t wb_rd,
  input  rv_pkg::word_t     wb_data
);

  rv_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // x0 reads zero, a same-cycle write is seen by decode
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wb_we && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wb_we && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

//--- verilog/rv_core.sv
////////////////////////////////////////////////////////////////////////////
// rv_core
// five-stage RV32I core with BTB prediction and two-level forwarding
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rv_core #(
  parameter int btb_index_bits = 5
) (
  input  logic              clk,
  input  logic              reset,
  output rv_pkg::word_t     imem_addr,
  input  rv_pkg::word_t     imem_data,
  output logic              retire_valid,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data,
  output rv_pkg::word_t     retire_pc,
  output logic              redirect
);

  rv_pkg::word_t redirect_pc, btb_target, btb_write_pc, btb_write_target;
  logic btb_hit, btb_write;
  logic id_valid;
  rv_pkg::word_t id_inst, id_pc, id_pred_pc;
  rv_pkg::reg_addr_t rs1_addr, rs2_addr;
  rv_pkg::word_t rs1_data, rs2_data;
  logic ex_valid, ex_use_imm, ex_is_branch, ex_is_jal, ex_is_jalr;
  logic ex_reg_write, ex_pc_to_reg;
  rv_pkg::word_t ex_pc, ex_pred_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  rv_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
  rv_pkg::alu_op_t ex_alu_op;
  rv_pkg::branch_cond_t ex_branch_cond;
  logic mem_valid, mem_reg_write, mem_pc_to_reg;
  rv_pkg::reg_addr_t mem_rd;
  rv_pkg::word_t mem_result, mem_pc;
  logic wb_we;
  rv_pkg::reg_addr_t wb_rd;
  rv_pkg::word_t wb_data;

  fetch_stage fetch_i (.*);

  branch_target_buffer #(.btb_index_bits(btb_index_bits)) btb_i (
    .clk, .reset, .lookup_pc(imem_addr), .btb_hit, .btb_target,
    .btb_write, .btb_write_pc, .btb_write_target
  );

  register_file regfile_i (.*);

  decode_stage decode_i (.flush(redirect), .*);

  execute_stage execute_i (.*);

  writeback_stage writeback_i (.*);

endmodule

//--- verilog/rv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// rv_pkg
// shared widths, opcodes and operation codes for the RV32I integer core
////////////////////////////////////////////////////////////////////////////
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  localparam word_t reset_pc = 32'h0000_0000;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b     // lui
  } alu_op_t;

  // encodings follow funct3 of the branch instructions
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_cond_t;

endpackage

//--- verilog/writeback_stage.sv
////////////////////////////////////////////////////////////////////////////
// writeback_stage
// MEM/WB register, link or result select, register write and retire port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module writeback_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_valid,
  input  rv_pkg::reg_addr_t mem_rd,
  input  rv_pkg::word_t     mem_result,
  input  rv_pkg::word_t     mem_pc,
  input  logic              mem_reg_write,
  input  logic              mem_pc_to_reg,
  output logic              wb_we,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data,
  output logic              retire_valid,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data,
  output rv_pkg::word_t     retire_pc
);

  logic          wb_valid;
  logic          wb_reg_write;
  rv_pkg::word_t wb_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_reg_write <= 1'b0;
    end else begin
      wb_valid <= mem_valid;
      wb_reg_write <= mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd <= mem_rd;
    wb_pc <= mem_pc;
    wb_data <= mem_pc_to_reg ? mem_pc + 32'd4 : mem_result;  // link or alu
  end

  assign wb_we = wb_valid && wb_reg_write && wb_rd != '0;  // x0 writes dropped

  assign retire_valid = wb_we;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;
  assign retire_pc    = wb_pc;

endmodule
